// File: hdl/datapath_functions.svh
////////////////////////////////////////////////////////////
// load extract, store merge and branch compare helpers
////////////////////////////////////////////////////////////
`ifndef DATAPATH_FUNCTIONS_SVH
`define DATAPATH_FUNCTIONS_SVH

// pick byte / half out of the read word and extend it
function automatic word_t load_compute(input logic [2:0] funct3, input word_t addr,
		input word_t rdata);
	logic [7:0]  b;
	logic [15:0] h;
	b = rdata[{addr[1:0], 3'b000} +: 8];
	h = addr[1] ? rdata[31:16] : rdata[15:0];
	case (funct3)
		3'b000:  load_compute = {{24{b[7]}}, b};  // lb
		3'b001:  load_compute = {{16{h[15]}}, h}; // lh
		3'b100:  load_compute = {24'b0, b};       // lbu
		3'b101:  load_compute = {16'b0, h};       // lhu
		default: load_compute = rdata;            // lw
	endcase
endfunction

// read-merge-write: new byte or half dropped into the old word
function automatic word_t store_compute(input logic [2:0] funct3, input word_t addr,
		input word_t rdata, input word_t sdata);
	word_t merged;
	merged = rdata;
	case (funct3)
		3'b000:  merged[{addr[1:0], 3'b000} +: 8] = sdata[7:0];  // sb
		3'b001:  merged[{addr[1], 4'b0000} +: 16] = sdata[15:0]; // sh
		default: merged = sdata;                                  // sw
	endcase
	store_compute = merged;
endfunction

// branch condition on rs1 / rs2
function automatic logic br_compute(input logic branch, input logic [2:0] funct3,
		input word_t a, input word_t b);
	logic taken;
	case (funct3)
		3'b000:  taken = (a == b);                 // beq
		3'b001:  taken = (a != b);                 // bne
		3'b100:  taken = ($signed(a) < $signed(b)); // blt
		3'b101:  taken = ($signed(a) >= $signed(b)); // bge
		3'b110:  taken = (a < b);                  // bltu
		3'b111:  taken = (a >= b);                 // bgeu
		default: taken = 1'b0;
	endcase
	br_compute = branch & taken;
endfunction

`endif

// File: hdl/rv_pkg.sv
////////////////////////////////////////////////////////////
// rv_pkg: shared types and control word of the RV32I core
////////////////////////////////////////////////////////////
package rv_pkg;

	localparam int XLEN = 32; // design only built for rv32

	typedef logic [XLEN-1:0] word_t;   // data, address or instruction
	typedef logic [4:0]      reg_idx_t; // x0..x31
	typedef logic [2:0]      alu_op_t;  // funct3 encoding

	// alu functions, same codes as funct3 of op/op-imm
	localparam alu_op_t ALU_ADD  = 3'b000; // sub when alu_sub
	localparam alu_op_t ALU_SLL  = 3'b001;
	localparam alu_op_t ALU_SLT  = 3'b010;
	localparam alu_op_t ALU_SLTU = 3'b011;
	localparam alu_op_t ALU_XOR  = 3'b100;
	localparam alu_op_t ALU_SR   = 3'b101; // sra when alu_sub
	localparam alu_op_t ALU_OR   = 3'b110;
	localparam alu_op_t ALU_AND  = 3'b111;

	// decoded control, one per instruction
	typedef struct packed {
		logic    regwrite; // write rd at edge
		logic    alusrc;   // srcb from immediate
		logic    memwrite;
		logic    memtoreg; // load result to rd
		logic    branch;
		logic    jump;     // jal
		logic    jalr;
		logic    lui;
		logic    auipc;
		logic    alu_sub;  // sub / sra select
		alu_op_t alucontrol;
	} ctrl_t;

endpackage : rv_pkg

// File: hdl/alu.sv
////////////////////////////////////////////////////////////
// alu: rv32i arithmetic, logic, shift and compare
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module alu
	import rv_pkg::*;
(
	input  word_t   srca,
	input  word_t   srcb,
	input  alu_op_t alucontrol,
	input  logic    alu_sub,
	output word_t   aluout
);

	logic [4:0] shamt;

	assign shamt = srcb[4:0]; // only low five bits shift

	always_comb begin
		case (alucontrol)
			ALU_ADD:  aluout = alu_sub ? srca - srcb : srca + srcb;
			ALU_SLL:  aluout = srca << shamt;
			ALU_SLT:  aluout = {31'b0, $signed(srca) < $signed(srcb)};
			ALU_SLTU: aluout = {31'b0, srca < srcb};
			ALU_XOR:  aluout = srca ^ srcb;
			ALU_SR: begin
				if (alu_sub) aluout = word_t'($signed(srca) >>> shamt); // sra
				else         aluout = srca >> shamt;
			end
			ALU_OR:   aluout = srca | srcb;
			ALU_AND:  aluout = srca & srcb;
			default:  aluout = '0;
		endcase
	end

endmodule : alu

// File: hdl/regfile.sv
////////////////////////////////////////////////////////////
// regfile: 32 x 32, two async reads, one write, x0 tied low
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module regfile
	import rv_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     we,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  word_t    wd,
	output word_t    rs1_data,
	output word_t    rs2_data
);

	word_t rf [32];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) rf <= '{default: '0};
		else if (!stall && we && rd != '0) rf[rd] <= wd; // held while waiting
	end

	assign rs1_data = (rs1 != '0) ? rf[rs1] : '0;
	assign rs2_data = (rs2 != '0) ? rf[rs2] : '0;

	a_x0_zero: assert property (@(posedge clk) disable iff (!reset)
		(rs1 == '0) |-> (rs1_data == '0))
		else $error("regfile: x0 read non-zero");

endmodule : regfile

// File: hdl/controller.sv
////////////////////////////////////////////////////////////
// controller: opcode / funct decode into the control word
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module controller
	import rv_pkg::*;
(
	input  word_t instr,
	input  logic  br_taken,
	output ctrl_t ctrl,
	output logic  pcsrc
);

	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       f7_5; // funct7 bit 5, sub / sra

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign f7_5   = instr[30];

	always_comb begin
		ctrl = '0; // unknown opcodes do nothing
		ctrl.alucontrol = ALU_ADD;
		case (opcode)
			OP_R: begin
				ctrl.regwrite   = 1'b1;
				ctrl.alucontrol = funct3;
				ctrl.alu_sub    = f7_5;
			end
			OP_IMM: begin
				ctrl.regwrite   = 1'b1;
				ctrl.alusrc     = 1'b1;
				ctrl.alucontrol = funct3;
				ctrl.alu_sub    = (funct3 == ALU_SR) & f7_5; // srai only, no subi
			end
			OP_LOAD: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1; // address = rs1 + imm
				ctrl.memtoreg = 1'b1;
			end
			OP_STORE: begin
				ctrl.alusrc   = 1'b1;
				ctrl.memwrite = 1'b1;
			end
			OP_BRANCH: begin
				ctrl.branch  = 1'b1;
				ctrl.alu_sub = 1'b1; // compare as subtract
			end
			OP_JAL:   {ctrl.regwrite, ctrl.jump}  = 2'b11;
			OP_JALR:  {ctrl.regwrite, ctrl.jalr}  = 2'b11;
			OP_LUI:   {ctrl.regwrite, ctrl.lui}   = 2'b11;
			OP_AUIPC: {ctrl.regwrite, ctrl.auipc} = 2'b11;
			default: ;
		endcase
	end

	assign pcsrc = ctrl.branch & br_taken;

	// next-pc sources are exclusive
	always_comb begin
		assert ($onehot0({ctrl.branch, ctrl.jump, ctrl.jalr}))
			else $error("controller: more than one pc source selected");
	end

endmodule : controller

// File: hdl/datapath.sv
////////////////////////////////////////////////////////////
// datapath: pc, immediates, operand / result muxes, rf, alu
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module datapath
	import rv_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  word_t instr,
	input  ctrl_t ctrl,
	input  logic  pcsrc,
	input  logic  Iwait,
	input  logic  Dwait,
	input  word_t readdata,
	output word_t pc,
	output word_t aluout,
	output word_t writedata,
	output logic  memaccess,
	output logic  br_taken
);

	`include "datapath_functions.svh"

	reg_idx_t   rs1, rs2, rd;
	logic [2:0] funct3;
	word_t      jumpimm, branchimm, utypeimm, stypeimm, itypeimm;
	word_t      srca, srcb, rs2_data;
	word_t      pcplus4, pc_next, result;
	logic       stall;

	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];

	assign jumpimm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign branchimm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign utypeimm  = {instr[31:12], 12'b0};
	assign stypeimm  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign itypeimm  = {{20{instr[31]}}, instr[31:20]}; // loads, jalr, op-imm

	assign stall     = Iwait | Dwait; // freezes pc and rf together
	assign pcplus4   = pc + 32'd4;
	assign memaccess = ctrl.memtoreg | ctrl.memwrite;

	regfile rf (.clk(clk), .reset(reset), .stall(stall), .we(ctrl.regwrite),
		.rs1(rs1), .rs2(rs2), .rd(rd), .wd(result),
		.rs1_data(srca), .rs2_data(rs2_data));

	// store offset is split, everything else uses i-type
	assign srcb = ctrl.alusrc ? (ctrl.memwrite ? stypeimm : itypeimm) : rs2_data;

	alu alu (.srca(srca), .srcb(srcb), .alucontrol(ctrl.alucontrol),
		.alu_sub(ctrl.alu_sub), .aluout(aluout));

	always_comb begin
		if (pcsrc)          pc_next = pc + branchimm;
		else if (ctrl.jump) pc_next = pc + jumpimm;
		else if (ctrl.jalr) pc_next = (srca + itypeimm) & ~32'd1; // lsb dropped
		else                pc_next = pcplus4;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) pc <= '0;
		else if (!stall) pc <= pc_next;
	end

	always_comb begin
		if (ctrl.jump | ctrl.jalr) result = pcplus4; // link
		else if (ctrl.auipc)       result = pc + utypeimm;
		else if (ctrl.lui)         result = utypeimm;
		else if (ctrl.memtoreg)    result = load_compute(funct3, aluout, readdata);
		else                       result = aluout;
	end

	assign writedata = store_compute(funct3, aluout, readdata, rs2_data);
	assign br_taken  = br_compute(ctrl.branch, funct3, srca, rs2_data);

	// no compressed isa, fetch stays word aligned
	a_pc_aligned: assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00)
		else $error("datapath: pc lost word alignment");

endmodule : datapath

// File: hdl/riscv_core.sv
////////////////////////////////////////////////////////////
// riscv_core: single-cycle rv32i, controller plus datapath
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module riscv_core
	import rv_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  word_t instr,
	input  word_t readdata,
	input  logic  Iwait,
	input  logic  Dwait,
	output word_t pc,
	output word_t aluout,    // data address
	output word_t writedata, // full merged word
	output logic  memaccess,
	output logic  memwrite
);

	ctrl_t ctrl;
	logic  pcsrc, br_taken;

	controller ctl (.instr(instr), .br_taken(br_taken), .ctrl(ctrl), .pcsrc(pcsrc));

	datapath dp (.clk(clk), .reset(reset), .instr(instr), .ctrl(ctrl), .pcsrc(pcsrc),
		.Iwait(Iwait), .Dwait(Dwait), .readdata(readdata), .pc(pc), .aluout(aluout),
		.writedata(writedata), .memaccess(memaccess), .br_taken(br_taken));

	assign memwrite = ctrl.memwrite;

endmodule : riscv_core

// File: dv/clk_gen.sv
////////////////////////////////////////////////////////////
// clk_gen: 10 ns clock and 10-cycle active-low reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk   = 1'b0;
		reset = 1'b0; // held for ten edges
		repeat (10) @(posedge clk);
		reset <= 1'b1;
	end

	always #5 clk = ~clk;

endmodule : clk_gen

// File: dv/tb_riscv_core.sv
////////////////////////////////////////////////////////////
// tb_riscv_core: memory models, random waits, store checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_riscv_core
	import rv_pkg::*;
();

	localparam int TIMEOUT = 5000; // cycles

	logic  clk, reset;
	logic  Iwait, Dwait;
	word_t instr, readdata;
	word_t pc, aluout, writedata;
	logic  memaccess, memwrite;

	word_t vec [512];  // raw vectors file
	word_t imem [256];
	word_t dmem [256];
	word_t exp_addr [64];
	word_t exp_data [64];
	int    prog_n, store_n;
	int    seen;        // committed stores so far
	logic [31:0] lfsr;
	word_t prev_pc;
	logic  prev_stall, prev_valid;
	int    cycles;

	clk_gen cg (.clk(clk), .reset(reset));

	riscv_core uut (.clk(clk), .reset(reset), .instr(instr), .readdata(readdata),
		.Iwait(Iwait), .Dwait(Dwait), .pc(pc), .aluout(aluout), .writedata(writedata),
		.memaccess(memaccess), .memwrite(memwrite));

	assign instr    = imem[pc[9:2]];     // comb fetch
	assign readdata = dmem[aluout[9:2]]; // comb read

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// data memory write, same condition as the core's own commit
	always @(posedge clk) begin
		if (reset && memwrite && !Iwait && !Dwait)
			dmem[aluout[9:2]] <= writedata;
	end

	// each wait high about one cycle in four
	always @(posedge clk) begin
		logic a, b, c, d;
		if (!reset) begin
			Iwait <= 1'b0;
			Dwait <= 1'b0;
		end else begin
			lfsr = lfsr_next(lfsr);
			a = lfsr[0];
			lfsr = lfsr_next(lfsr);
			b = lfsr[0];
			lfsr = lfsr_next(lfsr);
			c = lfsr[0];
			lfsr = lfsr_next(lfsr);
			d = lfsr[0];
			Iwait <= a & b;
			Dwait <= c & d;
		end
	end

	// monitor at negedge, everything settled there
	always @(negedge clk) begin
		if (!reset) begin
			prev_valid = 1'b0;
		end else begin
			if (prev_valid && prev_stall)
				check_value("pc", pc, prev_pc); // frozen across a stalled edge
			if (memwrite && !Iwait && !Dwait) begin
				if (seen >= store_n) begin
					$display("unexpected extra store at address %h", aluout);
					$display("Finished with errors");
					$fatal(1);
				end
				check_value("aluout", aluout, exp_addr[seen]);
				check_value("writedata", writedata, exp_data[seen]);
				seen = seen + 1;
			end
			prev_pc    = pc;
			prev_stall = Iwait | Dwait;
			prev_valid = 1'b1;
		end
	end

	initial begin
		int i;
		Iwait      <= 1'b0;
		Dwait      <= 1'b0;
		lfsr       = 32'hc50b;
		seen       = 0;
		prev_valid = 1'b0;
		prev_stall = 1'b0;
		prev_pc    = '0;
		for (i = 0; i < 256; i++) begin
			imem[i] = 32'h00000013;                        // nop
			dmem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0], 8'hc3}; // per-address fill
		end
		$readmemh("dv/core_vectors.txt", vec);
		prog_n = vec[0];
		for (i = 0; i < prog_n; i++)
			imem[i] = vec[1 + i];
		store_n = vec[1 + prog_n];
		for (i = 0; i < store_n; i++) begin
			exp_addr[i] = vec[2 + prog_n + 2 * i];
			exp_data[i] = vec[3 + prog_n + 2 * i];
		end

		// reset phase, first word is an add
		cycles = 0;
		@(posedge clk); // clear of time zero, reset already low
		while (!reset && cycles < 20) begin
			@(negedge clk);
			if (!reset) begin
				check_value("pc", pc, 32'h0);
				check_value("memwrite", {31'b0, memwrite}, 32'h0);
				check_value("memaccess", {31'b0, memaccess}, 32'h0);
			end
			cycles++;
		end
		if (!reset) begin
			$display("reset never released");
			$display("Finished with errors");
			$fatal(1);
		end
		check_value("pc", pc, 32'h0); // first negedge after release
		check_value("memwrite", {31'b0, memwrite}, 32'h0);
		check_value("memaccess", {31'b0, memaccess}, 32'h0);

		cycles = 0;
		while (seen < store_n && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (seen == store_n) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("timed out with %0d of %0d stores seen", seen, store_n);
			$display("Finished with errors");
			$fatal(1);
		end
	end

endmodule : tb_riscv_core

// File: build.f
hdl/rv_pkg.sv
+incdir+hdl
hdl/alu.sv
hdl/regfile.sv
hdl/controller.sv
hdl/datapath.sv
hdl/riscv_core.sv
dv/clk_gen.sv
dv/tb_riscv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_riscv_core -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
	exit 0
else
	echo "pass line not found in $LOG"
	exit 1
fi

// File: dv/core_vectors.txt
// program word count, then program words from address 0
// store count, then expected store pairs: address data
0000003A
00000033 FFB00093 00300113 402081B3
10302023 4020D233 10402223 001132B3
00411313 006283B3 10702423 102000A3
10000403 10204483 10005583 10801523
10902623 10B02823 00700013 10002A23
00000463 10070713 00208463 00170713
00209463 10070713 00001463 00170713
0020C463 10070713 00114463 00170713
00115463 10070713 0020D463 00170713
00116463 10070713 0020E463 00170713
0020F463 10070713 00117463 00170713
10E02C23 123457B7 10F02E23 00001817
13002023 008008EF 12102223 13102223
01088967 12102423 13202423 10A01503
12A02623 0000006F
0000000E
00000100 FFFFFFF8
00000104 FFFFFFFF
00000108 00000031
00000101 FFFF03F8
0000010A FFF80031
0000010C 000000FF
00000110 000003F8
00000114 00000000
00000118 00000006
0000011C 12345000
00000120 000010BC
00000124 000000C8
00000128 000000D4
0000012C FFFFFFF8
